/* hw/axi_bridge_pkg.sv */
package axi_bridge_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [3:0] axi_id_t;

    // reads are tagged by the port that issued them
    localparam axi_id_t inst_id = 4'd0;
    localparam axi_id_t data_id = 4'd1;

    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0] sram_size_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        sram_size_t        size;
    } rd_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        sram_size_t        size;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] data;
    } wr_req_t;

endpackage

/* hw/req_slot.sv */
`timescale 1ns/1ps

module req_slot
#(
    parameter type payload_t = logic
)
(
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     push,
    input  logic     pop,
    input  payload_t push_data,
    output logic     full,
    output payload_t data
);

    logic     full_q;
    payload_t data_q;

    // occupancy flag
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (push) begin
            full_q <= 1'b1;
        end else if (pop) begin
            full_q <= 1'b0;
        end
    end

    // payload only loads into an empty entry
    always_ff @(posedge aclk) begin
        if (push && !full_q) begin
            data_q <= push_data;
        end
    end

    assign full = full_q;
    assign data = data_q;

endmodule

/* hw/outstanding_counter.sv */
`timescale 1ns/1ps

module outstanding_counter
    import axi_bridge_pkg::*;
#(
    parameter int max_outstanding = 4
)
(
    input  logic    aclk,
    input  logic    arst_n,
    input  logic    issue,
    input  axi_id_t issue_id,
    input  logic    retire,
    input  axi_id_t retire_id,
    output logic    inst_full,
    output logic    data_full
);

    localparam int cnt_w = $clog2(max_outstanding + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(max_outstanding);

    // index 0 follows inst_id, index 1 follows data_id
    logic [cnt_w-1:0] cnt [2];
    logic [1:0]       up;
    logic [1:0]       dn;

    assign up[0] = issue && (issue_id == inst_id);
    assign up[1] = issue && (issue_id == data_id);
    assign dn[0] = retire && (retire_id == inst_id);
    assign dn[1] = retire && (retire_id == data_id);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                // issue and retire together leave the count as it is
                if (up[i] && !dn[i] && cnt[i] != cnt_max) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end else if (dn[i] && !up[i] && cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    assign inst_full = (cnt[0] == cnt_max);
    assign data_full = (cnt[1] == cnt_max);

endmodule

/* hw/bridge_fsm.sv */
`timescale 1ns/1ps

module bridge_fsm
    import axi_bridge_pkg::*;
(
    input  logic    aclk,
    input  logic    arst_n,
    input  logic    inst_req,
    input  logic    data_req,
    input  logic    data_wr,
    input  logic    inst_slot_full,
    input  logic    data_slot_full,
    input  logic    wr_slot_full,
    input  logic    inst_full,
    input  logic    data_full,
    input  logic    arready,
    input  logic    awready,
    input  logic    wready,
    input  logic    bvalid,
    output logic    inst_addr_ok,
    output logic    data_addr_ok,
    output logic    inst_pop,
    output logic    data_pop,
    output logic    wr_pop,
    output logic    arvalid,
    output axi_id_t arid,
    output logic    awvalid,
    output logic    wvalid
);

    typedef enum logic [1:0] {
        rd_idle,
        rd_inst,
        rd_data
    } rd_state_t;

    typedef enum logic [2:0] {
        wr_idle,
        wr_both,
        wr_addr_done,
        wr_data_done,
        wr_resp
    } wr_state_t;

    rd_state_t rd_state;
    rd_state_t rd_next;
    wr_state_t wr_state;
    wr_state_t wr_next;
    logic      wr_pending;
    logic      data_rd_acc;
    logic      data_wr_acc;
    logic      inst_waiting;
    logic      data_waiting;

    // write in flight, blocks all data port traffic
    assign wr_pending = (wr_state != wr_idle);

    assign inst_addr_ok = inst_req && !inst_slot_full && !inst_full;
    assign data_addr_ok = data_req && !wr_pending &&
                          (data_wr ? !wr_slot_full : (!data_slot_full && !data_full));

    assign data_rd_acc = data_addr_ok && !data_wr;
    assign data_wr_acc = data_addr_ok && data_wr;

    // held in the slot or captured this cycle
    assign inst_waiting = inst_slot_full || inst_addr_ok;
    assign data_waiting = data_slot_full || data_rd_acc;

    // read arbitration, data ahead of inst
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            rd_idle: begin
                if (data_waiting) begin
                    rd_next = rd_data;
                end else if (inst_waiting) begin
                    rd_next = rd_inst;
                end
            end
            rd_inst: begin
                if (arready) begin
                    rd_next = data_waiting ? rd_data : rd_idle;
                end
            end
            rd_data: begin
                if (arready) begin
                    rd_next = inst_waiting ? rd_inst : rd_idle;
                end
            end
            default: rd_next = rd_idle;
        endcase
    end

    // write sequencing, aw and w complete in either order
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            wr_idle: begin
                if (data_wr_acc) begin
                    wr_next = wr_both;
                end
            end
            wr_both: begin
                if (awready && wready) begin
                    wr_next = wr_resp;
                end else if (awready) begin
                    wr_next = wr_addr_done;
                end else if (wready) begin
                    wr_next = wr_data_done;
                end
            end
            wr_addr_done: begin
                if (wready) begin
                    wr_next = wr_resp;
                end
            end
            wr_data_done: begin
                if (awready) begin
                    wr_next = wr_resp;
                end
            end
            wr_resp: begin
                if (bvalid) begin
                    wr_next = wr_idle;
                end
            end
            default: wr_next = wr_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= rd_idle;
            wr_state <= wr_idle;
        end else begin
            rd_state <= rd_next;
            wr_state <= wr_next;
        end
    end

    assign arvalid  = (rd_state != rd_idle);
    assign arid     = (rd_state == rd_data) ? data_id : inst_id;
    assign inst_pop = (rd_state == rd_inst) && arready;
    assign data_pop = (rd_state == rd_data) && arready;

    assign awvalid = (wr_state == wr_both) || (wr_state == wr_data_done);
    assign wvalid  = (wr_state == wr_both) || (wr_state == wr_addr_done);
    // slot feeds awaddr and wdata until the response
    assign wr_pop  = (wr_state == wr_resp) && bvalid;

endmodule

/* hw/response_router.sv */
`timescale 1ns/1ps

module response_router
    import axi_bridge_pkg::*;
(
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              rvalid,
    input  axi_id_t           rid,
    input  logic [data_w-1:0] rdata,
    input  logic              bvalid,
    output logic              inst_data_ok,
    output logic [data_w-1:0] inst_rdata,
    output logic              data_data_ok,
    output logic [data_w-1:0] data_rdata
);

    logic inst_hit;
    logic data_hit;

    // rready is tied high, so rvalid alone is the handshake
    assign inst_hit = rvalid && (rid == inst_id);
    assign data_hit = rvalid && (rid == data_id);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            inst_data_ok <= 1'b0;
            data_data_ok <= 1'b0;
        end else begin
            inst_data_ok <= inst_hit;
            // write response shares the data port pulse
            data_data_ok <= data_hit || bvalid;
        end
    end

    // read data registers
    always_ff @(posedge aclk) begin
        if (inst_hit) begin
            inst_rdata <= rdata;
        end
        if (data_hit) begin
            data_rdata <= rdata;
        end
    end

endmodule

/* hw/sram_axi_bridge.sv */
`timescale 1ns/1ps

module sram_axi_bridge
    import axi_bridge_pkg::*;
#(
    parameter int max_outstanding = 4
)
(
    input  logic              aclk,
    input  logic              arst_n,
    // instruction port
    input  logic              inst_req,
    input  sram_size_t        inst_size,
    input  logic [addr_w-1:0] inst_addr,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,
    output logic [data_w-1:0] inst_rdata,
    // data port
    input  logic              data_req,
    input  logic              data_wr,
    input  sram_size_t        data_size,
    input  logic [strb_w-1:0] data_wstrb,
    input  logic [addr_w-1:0] data_addr,
    input  logic [data_w-1:0] data_wdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,
    output logic [data_w-1:0] data_rdata,
    // read address and data
    output axi_id_t           arid,
    output logic [addr_w-1:0] araddr,
    output logic [2:0]        arsize,
    output logic              arvalid,
    input  logic              arready,
    input  axi_id_t           rid,
    input  logic [data_w-1:0] rdata,
    input  logic              rvalid,
    output logic              rready,
    // write address, data and response
    output logic [addr_w-1:0] awaddr,
    output logic [2:0]        awsize,
    output logic              awvalid,
    input  logic              awready,
    output logic [data_w-1:0] wdata,
    output logic [strb_w-1:0] wstrb,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);

    rd_req_t inst_rd_in;
    rd_req_t inst_rd_q;
    rd_req_t data_rd_in;
    rd_req_t data_rd_q;
    rd_req_t ar_sel;
    wr_req_t wr_in;
    wr_req_t wr_q;
    logic    data_rd_push;
    logic    data_wr_push;
    logic    inst_slot_full;
    logic    data_slot_full;
    logic    wr_slot_full;
    logic    inst_pop;
    logic    data_pop;
    logic    wr_pop;
    logic    inst_full;
    logic    data_full;

    assign inst_rd_in = '{addr: inst_addr, size: inst_size};
    assign data_rd_in = '{addr: data_addr, size: data_size};
    assign wr_in      = '{addr: data_addr, size: data_size, strb: data_wstrb, data: data_wdata};

    // addr_ok already includes req
    assign data_rd_push = data_addr_ok && !data_wr;
    assign data_wr_push = data_addr_ok && data_wr;

    // slot currently presented on AR
    assign ar_sel = (arid == data_id) ? data_rd_q : inst_rd_q;
    assign araddr = ar_sel.addr;
    assign arsize = {1'b0, ar_sel.size};
    assign rready = 1'b1;

    assign awaddr = wr_q.addr;
    assign awsize = {1'b0, wr_q.size};
    assign wdata  = wr_q.data;
    assign wstrb  = wr_q.strb;
    assign bready = 1'b1;

    req_slot #(.payload_t(rd_req_t)) inst_slot_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .push      (inst_addr_ok),
        .pop       (inst_pop),
        .push_data (inst_rd_in),
        .full      (inst_slot_full),
        .data      (inst_rd_q)
    );

    req_slot #(.payload_t(rd_req_t)) data_slot_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .push      (data_rd_push),
        .pop       (data_pop),
        .push_data (data_rd_in),
        .full      (data_slot_full),
        .data      (data_rd_q)
    );

    req_slot #(.payload_t(wr_req_t)) wr_slot_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .push      (data_wr_push),
        .pop       (wr_pop),
        .push_data (wr_in),
        .full      (wr_slot_full),
        .data      (wr_q)
    );

    bridge_fsm bridge_fsm_inst (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .inst_req       (inst_req),
        .data_req       (data_req),
        .data_wr        (data_wr),
        .inst_slot_full (inst_slot_full),
        .data_slot_full (data_slot_full),
        .wr_slot_full   (wr_slot_full),
        .inst_full      (inst_full),
        .data_full      (data_full),
        .arready        (arready),
        .awready        (awready),
        .wready         (wready),
        .bvalid         (bvalid),
        .inst_addr_ok   (inst_addr_ok),
        .data_addr_ok   (data_addr_ok),
        .inst_pop       (inst_pop),
        .data_pop       (data_pop),
        .wr_pop         (wr_pop),
        .arvalid        (arvalid),
        .arid           (arid),
        .awvalid        (awvalid),
        .wvalid         (wvalid)
    );

    outstanding_counter #(.max_outstanding(max_outstanding)) outstanding_counter_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .issue     (arvalid && arready),
        .issue_id  (arid),
        .retire    (rvalid),
        .retire_id (rid),
        .inst_full (inst_full),
        .data_full (data_full)
    );

    response_router response_router_inst (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .rvalid       (rvalid),
        .rid          (rid),
        .rdata        (rdata),
        .bvalid       (bvalid),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata)
    );

endmodule

/* verif/bridge_assertions.sv */
`timescale 1ns/1ps

module bridge_assertions
    import axi_bridge_pkg::*;
(
    input logic              aclk,
    input logic              arst_n,
    input logic              arvalid,
    input logic              arready,
    input logic [addr_w-1:0] araddr,
    input axi_id_t           arid,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready
);

    int fail_count = 0;

    // read address held with a stable payload until accepted
    ar_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else begin
            $error("arvalid or its payload changed before arready");
            fail_count++;
        end

    aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    // nothing may be issued while in reset
    no_valid_in_reset: assert property (@(posedge aclk)
        !arst_n |-> !arvalid && !awvalid)
        else begin
            $error("address valid raised during reset");
            fail_count++;
        end

endmodule

bind sram_axi_bridge bridge_assertions bridge_assertions_inst (.*);

/* verif/tb_sram_axi_bridge.sv */
`timescale 1ns/1ps

module tb_sram_axi_bridge
    import axi_bridge_pkg::*;
;

    localparam int max_outstanding = 4;
    localparam logic [31:0] fill_pattern = 32'h5a3c_96e1;

    typedef struct packed {
        int                phase;
        int                port;
        logic              wr;
        logic [addr_w-1:0] addr;
        sram_size_t        size;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] exp;
    } stim_t;

    typedef struct packed {
        logic              wr;
        logic [data_w-1:0] exp;
    } exp_t;

    logic aclk = 1'b0;
    logic arst_n;
    logic inst_req, data_req, data_wr;
    sram_size_t inst_size, data_size;
    logic [addr_w-1:0] inst_addr, data_addr;
    logic [strb_w-1:0] data_wstrb;
    logic [data_w-1:0] data_wdata;
    logic inst_addr_ok, inst_data_ok, data_addr_ok, data_data_ok;
    logic [data_w-1:0] inst_rdata, data_rdata;
    axi_id_t arid, rid;
    logic [addr_w-1:0] araddr, awaddr;
    logic [2:0] arsize, awsize;
    logic arvalid, arready, rvalid, rready;
    logic [data_w-1:0] rdata, wdata;
    logic [strb_w-1:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;

    stim_t stim[$];
    exp_t inst_exp[$];
    exp_t data_exp[$];
    sram_size_t ar_size_inst[$];
    sram_size_t ar_size_data[$];
    sram_size_t aw_size_exp;
    logic [data_w-1:0] ref_mem[int unsigned];
    logic [data_w-1:0] mem[int unsigned];
    logic [addr_w-1:0] rq_inst[$];
    logic [addr_w-1:0] rq_data[$];
    logic [15:0] lfsr = 16'd67;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 1000000;
    int cur_phase = 0;
    int peak_total = 0;
    int peak_id = 0;
    logic ar_block = 1'b0;
    logic arready_q;

    // model state
    logic ar_hs, aw_hs, w_hs;
    axi_id_t ar_id_s;
    logic [2:0] ar_size_s, aw_size_s;
    logic [addr_w-1:0] ar_addr_s, aw_addr_s, aw_addr_q;
    logic [data_w-1:0] w_data_s, w_data_q;
    logic [strb_w-1:0] w_strb_s, w_strb_q;
    logic aw_got, w_got, b_arm;
    int ar_dly, r_dly, aw_dly, w_dly, b_dly;

    always #20 aclk = ~aclk;

    assign arready = arready_q && !ar_block;

    sram_axi_bridge #(.max_outstanding(max_outstanding)) sram_axi_bridge_inst (.*);

    function automatic logic [data_w-1:0] pattern(input logic [addr_w-1:0] addr);
        return {addr[addr_w-1:2], 2'b00} ^ fill_pattern;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
        if (mem.exists(addr >> 2)) begin
            return mem[addr >> 2];
        end
        return pattern(addr);
    endfunction

    task automatic check_rdata(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // expected values follow the fill rule with strobe merges in table order
    task automatic add(input int ph, input int port, input logic wr,
                       input logic [addr_w-1:0] addr, input sram_size_t size,
                       input logic [strb_w-1:0] strb, input logic [data_w-1:0] wd);
        stim_t s;
        logic [data_w-1:0] w;
        s = '{ph, port, wr, addr, size, strb, wd, '0};
        w = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2] : pattern(addr);
        if (wr) begin
            for (int b = 0; b < strb_w; b++) begin
                if (strb[b]) begin
                    w[8*b +: 8] = wd[8*b +: 8];
                end
            end
            ref_mem[addr >> 2] = w;
        end else begin
            s.exp = w;
        end
        stim.push_back(s);
    endtask

    task automatic drive_req(input int port, input int i, input logic on);
        if (port == 0) begin
            inst_req  = on;
            inst_size = stim[i].size;
            inst_addr = stim[i].addr;
        end else begin
            data_req   = on;
            data_wr    = stim[i].wr;
            data_size  = stim[i].size;
            data_wstrb = stim[i].strb;
            data_addr  = stim[i].addr;
            data_wdata = stim[i].wdata;
        end
    endtask

    task automatic push_exp(input int port, input int i);
        exp_t e;
        e = '{stim[i].wr, stim[i].exp};
        if (port == 0) begin
            inst_exp.push_back(e);
            ar_size_inst.push_back(stim[i].size);
        end else begin
            data_exp.push_back(e);
            if (stim[i].wr) begin
                aw_size_exp = stim[i].size;
            end else begin
                ar_size_data.push_back(stim[i].size);
            end
        end
    endtask

    task automatic drain(input int port);
        while ((port == 0 ? inst_exp.size() : data_exp.size()) != 0) begin
            @(posedge aclk);
            #2;
        end
    endtask

    // issues one port's entries of a phase back to back
    task automatic run_port(input int port, input int ph);
        for (int i = 0; i < stim.size(); i++) begin
            if (stim[i].phase == ph && stim[i].port == port) begin
                // a write waits for earlier data answers
                if (stim[i].wr) begin
                    drain(1);
                end
                drive_req(port, i, 1'b1);
                @(negedge aclk);
                while (!(port == 0 ? inst_addr_ok : data_addr_ok)) begin
                    @(negedge aclk);
                end
                push_exp(port, i);
                @(posedge aclk);
                #2;
                drive_req(port, i, 1'b0);
            end
        end
    endtask

    task automatic run_phase(input int ph, input string name);
        int e0;
        e0 = errors;
        cur_phase = ph;
        fork
            run_port(0, ph);
            run_port(1, ph);
        join
        drain(0);
        drain(1);
        if (ph == 3) begin
            checks++;
            if (peak_total < 2) begin
                errors++;
                $display("concurrent reads never had more than one read in flight");
            end
            if (peak_id > max_outstanding) begin
                errors++;
                $display("reads in flight for one id exceeded %0d", max_outstanding);
            end
        end
        $display("test %0d %s: %0d errors", ph + 1, name, errors - e0);
    endtask

    task automatic run_backpressure();
        int e0;
        int ia;
        int da;
        int ii;
        int di;
        e0 = errors;
        ia = 0;
        da = 0;
        ii = -1;
        di = -1;
        cur_phase = 4;
        for (int i = 0; i < stim.size(); i++) begin
            if (stim[i].phase == 4 && stim[i].port == 0 && ii < 0) ii = i;
            if (stim[i].phase == 4 && stim[i].port == 1 && di < 0) di = i;
        end
        ar_block = 1'b1;
        drive_req(0, ii, 1'b1);
        drive_req(1, di, 1'b1);
        repeat (30) begin
            @(negedge aclk);
            if (inst_addr_ok) begin
                ia++;
                if (ia == 1) push_exp(0, ii);
            end
            if (data_addr_ok) begin
                da++;
                if (da == 1) push_exp(1, di);
            end
            @(posedge aclk);
            #2;
        end
        drive_req(0, ii, 1'b0);
        drive_req(1, di, 1'b0);
        check_count("inst accepts", ia, 1);
        check_count("data accepts", da, 1);
        ar_block = 1'b0;
        drain(0);
        drain(1);
        $display("test 5 back-pressure: %0d errors", errors - e0);
    endtask

    // AXI slave memory sampled mid-cycle and driven after the edge
    always begin
        @(negedge aclk);
        ar_hs     = arvalid && arready;
        ar_id_s   = arid;
        ar_addr_s = araddr;
        ar_size_s = arsize;
        aw_hs     = awvalid && awready;
        aw_addr_s = awaddr;
        aw_size_s = awsize;
        w_hs      = wvalid && wready;
        w_data_s  = wdata;
        w_strb_s  = wstrb;
        @(posedge aclk);
        #2;
        rvalid = 1'b0;
        bvalid = 1'b0;
        if (!arst_n) begin
            arready_q = 1'b0;
            awready   = 1'b0;
            wready    = 1'b0;
            {ar_dly, r_dly, aw_dly, w_dly, b_dly} = '0;
            {aw_got, w_got, b_arm} = '0;
        end else begin
            if (ar_hs) begin
                if (cur_phase == 1) check_id("arid", ar_id_s, inst_id);
                if (ar_id_s == data_id) begin
                    rq_data.push_back(ar_addr_s);
                    check_count("arsize", int'(ar_size_s), int'(ar_size_data.pop_front()));
                end else begin
                    rq_inst.push_back(ar_addr_s);
                    check_count("arsize", int'(ar_size_s), int'(ar_size_inst.pop_front()));
                end
                ar_dly = rand_bits(2);
            end else if (ar_dly > 0) begin
                ar_dly--;
            end
            arready_q = (ar_dly == 0);
            if (cur_phase == 3 && rq_inst.size() + rq_data.size() > peak_total) begin
                peak_total = rq_inst.size() + rq_data.size();
            end
            if (rq_inst.size() > peak_id) peak_id = rq_inst.size();
            if (rq_data.size() > peak_id) peak_id = rq_data.size();
            // in order per id with a random choice between ids
            if (r_dly > 0) begin
                r_dly--;
            end else if (rq_inst.size() + rq_data.size() > 0) begin
                rvalid = 1'b1;
                if (rq_data.size() > 0 && (rq_inst.size() == 0 || rand_bits(1) == 1)) begin
                    rid   = data_id;
                    rdata = mem_word(rq_data.pop_front());
                end else begin
                    rid   = inst_id;
                    rdata = mem_word(rq_inst.pop_front());
                end
                r_dly = rand_bits(2);
            end
            if (aw_hs) begin
                check_count("awsize", int'(aw_size_s), int'(aw_size_exp));
                aw_got    = 1'b1;
                aw_addr_q = aw_addr_s;
                aw_dly    = rand_bits(2);
            end else if (aw_dly > 0) begin
                aw_dly--;
            end
            if (w_hs) begin
                w_got    = 1'b1;
                w_data_q = w_data_s;
                w_strb_q = w_strb_s;
                w_dly    = rand_bits(2);
            end else if (w_dly > 0) begin
                w_dly--;
            end
            awready = (aw_dly == 0);
            wready  = (w_dly == 0);
            if (aw_got && w_got && !b_arm) begin
                mem[aw_addr_q >> 2] = mem_word(aw_addr_q);
                for (int b = 0; b < strb_w; b++) begin
                    if (w_strb_q[b]) mem[aw_addr_q >> 2][8*b +: 8] = w_data_q[8*b +: 8];
                end
                b_arm = 1'b1;
                b_dly = rand_bits(2);
            end else if (b_arm) begin
                if (b_dly == 0) begin
                    bvalid = 1'b1;
                    {aw_got, w_got, b_arm} = '0;
                end else begin
                    b_dly--;
                end
            end
        end
    end

    // answers are checked against each port's own order
    always @(negedge aclk) begin
        exp_t e;
        if (arst_n && rvalid) begin
            check_count("rready", int'(rready), 1);
        end
        if (arst_n && bvalid) begin
            check_count("bready", int'(bready), 1);
        end
        if (arst_n && inst_data_ok) begin
            if (inst_exp.size() == 0) begin
                errors++;
                $display("inst_data_ok at %0t with no request outstanding", $time);
            end else begin
                e = inst_exp.pop_front();
                check_rdata("inst_rdata", inst_rdata, e.exp);
            end
        end
        if (arst_n && data_data_ok) begin
            if (data_exp.size() == 0) begin
                errors++;
                $display("data_data_ok at %0t with no request outstanding", $time);
            end else begin
                e = data_exp.pop_front();
                if (!e.wr) check_rdata("data_rdata", data_rdata, e.exp);
                else checks++;
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_idle(input string when);
        check_count({"arvalid ", when}, int'(arvalid), 0);
        check_count({"awvalid ", when}, int'(awvalid), 0);
        check_count({"wvalid ", when}, int'(wvalid), 0);
        check_count({"inst_data_ok ", when}, int'(inst_data_ok), 0);
        check_count({"data_data_ok ", when}, int'(data_data_ok), 0);
    endtask

    initial begin
        arst_n = 1'b0;
        {inst_req, data_req, data_wr, inst_size, data_size} = '0;
        {inst_addr, data_addr, data_wstrb, data_wdata} = '0;
        {arready_q, rvalid, rid, rdata, awready, wready, bvalid} = '0;
        for (int i = 0; i < 6; i++) add(1, 0, 0, 32'h100 + 4 * i, 2, 0, 0);
        add(2, 1, 1, 32'h401, 0, 4'b0010, 32'h0000_ab00);
        add(2, 1, 1, 32'h406, 1, 4'b1100, 32'hbeef_0000);
        add(2, 1, 1, 32'h408, 2, 4'b1111, 32'h1234_5678);
        add(2, 1, 0, 32'h400, 2, 0, 0);
        add(2, 1, 0, 32'h404, 2, 0, 0);
        add(2, 1, 0, 32'h408, 2, 0, 0);
        add(2, 1, 0, 32'h40c, 2, 0, 0);
        for (int i = 0; i < 6; i++) begin
            add(3, 0, 0, 32'h1000 + 4 * i, 2, 0, 0);
            add(3, 1, 0, 32'h2000 + 8 * i, 2, 0, 0);
        end
        add(3, 1, 0, 32'h408, 2, 0, 0);
        add(4, 0, 0, 32'h3000, 2, 0, 0);
        add(4, 1, 0, 32'h3104, 2, 0, 0);
        limit = stim.size() * 12 + 200;
        repeat (8) begin
            @(negedge aclk);
            check_idle("in reset");
        end
        @(posedge aclk);
        #2;
        arst_n = 1'b1;
        @(negedge aclk);
        check_idle("after reset");
        $display("test 1 reset: %0d errors", errors);
        @(posedge aclk);
        #2;
        run_phase(1, "instruction reads");
        run_phase(2, "write then read");
        run_phase(3, "concurrent reads");
        run_backpressure();
        // protocol assertion failures count as errors too
        errors += sram_axi_bridge_inst.bridge_assertions_inst.fail_count;
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
hw/axi_bridge_pkg.sv
hw/req_slot.sv
hw/outstanding_counter.sv
hw/bridge_fsm.sv
hw/response_router.sv
hw/sram_axi_bridge.sv
verif/bridge_assertions.sv
verif/tb_sram_axi_bridge.sv
